/* Makefile */
LOG = sim.log

all: run

run:
	verilator --binary -j 0 --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module cpu_tb -f cpu.f
	./obj_dir/Vcpu_tb | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module cpu -f cpu.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

/* cpu.f */
+incdir+.
cpu_pkg.sv
register_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu.sv
cpu_tb.sv

/* cpu.sv */
`timescale 1ns/1ps

module cpu #(
  parameter int FETCH_DEPTH = 4
) (
  input  logic           clock,
  input  logic           rst_n,
  output logic           imemory_valid,
  output logic           imemory_instr,
  output logic           imemory_store,
  output cpu_pkg::addr_t imemory_addr,
  output cpu_pkg::word_t imemory_wdata,
  input  cpu_pkg::word_t imemory_rdata,
  input  logic           imemory_ready,
  output logic           dmemory_valid,
  output logic           dmemory_instr,
  output logic           dmemory_store,
  output cpu_pkg::addr_t dmemory_addr,
  output cpu_pkg::word_t dmemory_wdata,
  input  cpu_pkg::word_t dmemory_rdata,
  input  logic           dmemory_ready
);

  cpu_pkg::mem_req_t imem_req;
  cpu_pkg::mem_rsp_t imem_rsp;
  cpu_pkg::mem_req_t dmem_req;
  cpu_pkg::mem_rsp_t dmem_rsp;
  cpu_pkg::fetch_out_t fetch_out;
  cpu_pkg::issue_t issue_out;
  cpu_pkg::execute_out_t exec_out;
  cpu_pkg::reg_write_t reg_wr;
  cpu_pkg::reg_addr_t rs1_addr;
  cpu_pkg::reg_addr_t rs2_addr;
  cpu_pkg::word_t rs1_data;
  cpu_pkg::word_t rs2_data;
  cpu_pkg::reg_addr_t ex_rd;
  cpu_pkg::reg_addr_t mem_rd;
  logic ex_writes;
  logic mem_writes;
  logic fetch_valid;
  logic fetch_ready;
  logic issue_valid;
  logic issue_ready;
  logic exec_valid;
  logic exec_ready;

  fetch_stage #(
    .FETCH_DEPTH(FETCH_DEPTH)
  ) fetch_stage_i (
    .clock, .rst_n,
    .imem_req, .imem_rsp,
    .fetch_out, .fetch_valid, .fetch_ready
  );

  decode_stage decode_stage_i (
    .clock, .rst_n,
    .fetch_in(fetch_out), .fetch_valid, .fetch_ready,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .ex_rd, .mem_rd, .ex_writes, .mem_writes,
    .issue_out, .issue_valid, .issue_ready
  );

  execute_stage execute_stage_i (
    .clock, .rst_n,
    .issue_in(issue_out), .issue_valid, .issue_ready,
    .exec_out, .exec_valid, .exec_ready,
    .ex_rd, .ex_writes
  );

  memory_stage memory_stage_i (
    .clock, .rst_n,
    .exec_in(exec_out), .exec_valid, .exec_ready,
    .dmem_req, .dmem_rsp,
    .reg_wr, .mem_rd, .mem_writes
  );

  register_file register_file_i (
    .clock, .rst_n,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .wr(reg_wr)
  );

  // Port structs split into the flat bus fields.
  assign {imemory_valid, imemory_instr, imemory_store, imemory_addr, imemory_wdata} = imem_req;
  assign imem_rsp = '{rdata: imemory_rdata, ready: imemory_ready};
  assign {dmemory_valid, dmemory_instr, dmemory_store, dmemory_addr, dmemory_wdata} = dmem_req;
  assign dmem_rsp = '{rdata: dmemory_rdata, ready: dmemory_ready};

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0] reg_addr_t; // Sixteen registers.
  typedef logic [6:0] opcode_t;

  // Major opcodes of the supported subset.
  localparam opcode_t OPC_REG = 7'b0110011;
  localparam opcode_t OPC_IMM = 7'b0010011;
  localparam opcode_t OPC_LOAD = 7'b0000011;
  localparam opcode_t OPC_STORE = 7'b0100011;

  typedef enum logic [3:0] {
    OP_NOP,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_LW,
    OP_SW
  } op_t;

  typedef struct packed {
    word_t instr;
    addr_t pc;
  } fetch_out_t;

  typedef struct packed {
    op_t op;
    reg_addr_t rd;
    word_t rs1_val;
    word_t rs2_val;
    word_t imm; // Already sign extended.
    logic writes;
  } issue_t;

  typedef struct packed {
    op_t op;
    reg_addr_t rd;
    word_t result; // ALU result or data address.
    word_t store_data;
    logic writes;
  } execute_out_t;

  typedef struct packed {
    logic valid;
    logic instr;
    logic store;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    word_t rdata;
    logic ready;
  } mem_rsp_t;

  typedef struct packed {
    logic en;
    reg_addr_t rd;
    word_t data;
  } reg_write_t;

endpackage

/* cpu_tb_model.svh */
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

// Architectural state, stepped once per generated instruction.
cpu_pkg::word_t model_regs [16];
cpu_pkg::word_t model_mem [512];
cpu_pkg::addr_t exp_addr [$]; // Stores in program order.
cpu_pkg::word_t exp_data [$];

task automatic model_step(input cpu_pkg::op_t op, input int rd, input int rs1, input int rs2,
                          input int imm);
  cpu_pkg::word_t a;
  cpu_pkg::word_t b;
  cpu_pkg::word_t sum;
  cpu_pkg::word_t r;
  a = model_regs[rs1];
  b = model_regs[rs2];
  sum = a + cpu_pkg::word_t'(imm);
  r = '0;
  case (op)
    cpu_pkg::OP_ADD: r = a + b;
    cpu_pkg::OP_SUB: r = a - b;
    cpu_pkg::OP_AND: r = a & b;
    cpu_pkg::OP_OR: r = a | b;
    cpu_pkg::OP_XOR: r = a ^ b;
    cpu_pkg::OP_ADDI: r = sum;
    cpu_pkg::OP_LW: r = model_mem[sum[10:2]];
    cpu_pkg::OP_SW: begin
      model_mem[sum[10:2]] = b;
      exp_addr.push_back(sum);
      exp_data.push_back(b);
    end
    default: ;
  endcase
  if (op != cpu_pkg::OP_SW && rd != 0) model_regs[rd] = r; // x0 stays zero.
endtask

`endif

/* cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

  localparam int N_RANDOM = 200;
  localparam int PROG_LEN = N_RANDOM + 15; // Random body, then the register dump.
  localparam int WORST_CPI = 20;
  localparam int LIMIT_NS = (PROG_LEN * WORST_CPI + 10) * 40;
  localparam cpu_pkg::word_t NOP_WORD = 32'h0000_0013; // ADDI x0, x0, 0.

  logic clock;
  logic rst_n;
  logic imemory_valid, imemory_instr, imemory_store, imemory_ready;
  logic dmemory_valid, dmemory_instr, dmemory_store, dmemory_ready;
  cpu_pkg::addr_t imemory_addr, dmemory_addr;
  cpu_pkg::word_t imemory_wdata, imemory_rdata, dmemory_wdata, dmemory_rdata;

  integer seed = 32'h04622c95;
  cpu_pkg::word_t program_mem [PROG_LEN];
  cpu_pkg::word_t data_mem [512];
  cpu_pkg::addr_t fetch_pc = '0;
  int stores_seen = 0;
  int stores_total;

  `include "cpu_tb_model.svh"

  cpu #(.FETCH_DEPTH(4)) cpu_i (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_fetch_addr(input cpu_pkg::addr_t got, input cpu_pkg::addr_t want);
    if (got !== want)
      stop_with_failure($sformatf("ERR %0t: fetch address %h, expected %h", $time, got, want));
  endtask

  task automatic check_fetch_wdata(input cpu_pkg::word_t got);
    if (got !== '0)
      stop_with_failure($sformatf("ERR %0t: fetch write data %h, expected 0", $time, got));
  endtask

  task automatic check_req_flag(input logic got, input logic want, input string what);
    if (got !== want)
      stop_with_failure($sformatf("ERR %0t: %s flag %b, expected %b", $time, what, got, want));
  endtask

  task automatic check_store_addr(input cpu_pkg::addr_t got, input cpu_pkg::addr_t want);
    if (got !== want)
      stop_with_failure($sformatf("ERR %0t: store address %h, expected %h", $time, got, want));
  endtask

  task automatic check_store_data(input cpu_pkg::word_t got, input cpu_pkg::word_t want);
    if (got !== want)
      stop_with_failure($sformatf("ERR %0t: store data %h, expected %h", $time, got, want));
  endtask

  function automatic cpu_pkg::word_t encode(input cpu_pkg::op_t op, input int rd, input int rs1,
                                            input int rs2, input int imm);
    logic [4:0] d;
    logic [4:0] s1;
    logic [4:0] s2;
    logic [11:0] i;
    d = 5'(rd);
    s1 = 5'(rs1);
    s2 = 5'(rs2);
    i = 12'(imm);
    case (op)
      cpu_pkg::OP_ADD: return {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
      cpu_pkg::OP_SUB: return {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
      cpu_pkg::OP_AND: return {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
      cpu_pkg::OP_OR: return {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
      cpu_pkg::OP_XOR: return {7'b0000000, s2, s1, 3'b100, d, 7'b0110011};
      cpu_pkg::OP_ADDI: return {i, s1, 3'b000, d, 7'b0010011};
      cpu_pkg::OP_LW: return {i, s1, 3'b010, d, 7'b0000011};
      cpu_pkg::OP_SW: return {i[11:5], s2, s1, 3'b010, i[4:0], 7'b0100011};
      default: return NOP_WORD;
    endcase
  endfunction

  function automatic cpu_pkg::word_t instr_at(input cpu_pkg::addr_t a);
    if (a < 32'(4 * PROG_LEN)) return program_mem[a[9:2]];
    return NOP_WORD;
  endfunction

  task automatic build_program();
    cpu_pkg::op_t op;
    int rd;
    int rs1;
    int rs2;
    int imm;
    int prev_rd;
    logic after_load;
    after_load = 1'b0;
    prev_rd = 0;
    foreach (model_regs[k]) model_regs[k] = '0;
    for (int n = 0; n < 512; n++) begin
      data_mem[n] = $random(seed) ^ {n[15:0], n[15:0]};
      model_mem[n] = data_mem[n];
    end
    for (int n = 0; n < N_RANDOM; n++) begin
      op = cpu_pkg::op_t'(1 + {$random(seed)} % 8);
      rd = {$random(seed)} % 16;
      rs1 = {$random(seed)} % 16;
      rs2 = {$random(seed)} % 16;
      imm = $random(seed) % 2048;
      if (op inside {cpu_pkg::OP_LW, cpu_pkg::OP_SW}) begin
        rs1 = 0; // Base x0, aligned offset into the data area.
        imm = 4 * ({$random(seed)} % 256);
      end
      // Consume the loaded register right away.
      if (after_load) begin
        if (op == cpu_pkg::OP_SW) rs2 = prev_rd;
        else if (op != cpu_pkg::OP_LW) rs1 = prev_rd;
      end
      after_load = (op == cpu_pkg::OP_LW);
      prev_rd = rd;
      program_mem[n] = encode(op, rd, rs1, rs2, imm);
      model_step(op, rd, rs1, rs2, imm);
    end
    for (int r = 1; r < 16; r++) begin
      program_mem[N_RANDOM + r - 1] = encode(cpu_pkg::OP_SW, 0, 0, r, 1024 + 4 * r);
      model_step(cpu_pkg::OP_SW, 0, 0, r, 1024 + 4 * r);
    end
    stores_total = exp_addr.size();
  endtask

  initial begin
    rst_n = 1'b0;
    imemory_ready = 1'b0;
    imemory_rdata = '0;
    dmemory_ready = 1'b0;
    dmemory_rdata = '0;
    build_program();
    repeat (5) @(posedge clock);
    #2;
    rst_n = 1'b1;
    wait (stores_seen == stores_total);
    $display("*** TEST PASSED ***");
    $finish;
  end

  // Both memory ports. Sampled mid-cycle, driven just after the edge.
  initial begin
    logic ifire;
    logic dfire;
    int idelay;
    int ddelay;
    idelay = 0;
    ddelay = 0;
    forever begin
      @(negedge clock);
      if (!rst_n && (imemory_valid === 1'b1 || dmemory_valid === 1'b1))
        stop_with_failure("A memory request was valid while reset was asserted.");
      ifire = rst_n && imemory_valid && imemory_ready;
      dfire = rst_n && dmemory_valid && dmemory_ready;
      if (ifire) begin
        check_fetch_addr(imemory_addr, fetch_pc);
        check_req_flag(imemory_instr, 1'b1, "fetch instr");
        check_req_flag(imemory_store, 1'b0, "fetch store");
        check_fetch_wdata(imemory_wdata);
        fetch_pc = fetch_pc + 32'd4;
      end
      if (dfire) check_req_flag(dmemory_instr, 1'b0, "data instr");
      if (dfire && dmemory_store) begin
        check_store_addr(dmemory_addr, exp_addr.pop_front());
        check_store_data(dmemory_wdata, exp_data.pop_front());
        data_mem[dmemory_addr[10:2]] = dmemory_wdata;
        stores_seen++;
      end
      @(posedge clock);
      #2;
      if (ifire) idelay = {$random(seed)} % 4;
      if (dfire) ddelay = {$random(seed)} % 4;
      imemory_ready = 1'b0;
      dmemory_ready = 1'b0;
      if (imemory_valid === 1'b1) begin
        if (idelay == 0) begin
          imemory_ready = 1'b1;
          imemory_rdata = instr_at(imemory_addr);
        end else begin
          idelay--;
        end
      end
      if (dmemory_valid === 1'b1) begin
        if (ddelay == 0) begin
          dmemory_ready = 1'b1;
          dmemory_rdata = data_mem[dmemory_addr[10:2]];
        end else begin
          ddelay--;
        end
      end
    end
  end

  initial begin
    #(LIMIT_NS);
    stop_with_failure("Timeout: the core did not complete all expected stores in time.");
  end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic                clock,
  input  logic                rst_n,
  input  cpu_pkg::fetch_out_t fetch_in,
  input  logic                fetch_valid,
  output logic                fetch_ready,
  output cpu_pkg::reg_addr_t  rs1_addr,
  output cpu_pkg::reg_addr_t  rs2_addr,
  input  cpu_pkg::word_t      rs1_data,
  input  cpu_pkg::word_t      rs2_data,
  input  cpu_pkg::reg_addr_t  ex_rd,
  input  cpu_pkg::reg_addr_t  mem_rd,
  input  logic                ex_writes,
  input  logic                mem_writes,
  output cpu_pkg::issue_t     issue_out,
  output logic                issue_valid,
  input  logic                issue_ready
);

  cpu_pkg::opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  cpu_pkg::op_t op;
  cpu_pkg::reg_addr_t rd;
  cpu_pkg::word_t imm;
  logic writes;
  logic use_rs2;
  logic rs1_busy;
  logic rs2_busy;
  logic own_writes;
  logic hazard;
  logic take;

  function automatic logic hits(input cpu_pkg::reg_addr_t src, input cpu_pkg::reg_addr_t dst,
                                input logic wr);
    return wr && (src == dst);
  endfunction

  assign opcode = fetch_in.instr[6:0];
  assign funct3 = fetch_in.instr[14:12];
  assign funct7 = fetch_in.instr[31:25];
  assign rd = fetch_in.instr[10:7]; // Low four bits only.
  assign rs1_addr = fetch_in.instr[18:15];
  assign rs2_addr = fetch_in.instr[23:20];

  always_comb begin
    op = cpu_pkg::OP_NOP; // Anything unrecognized.
    case (opcode)
      cpu_pkg::OPC_REG: begin
        if (funct7 == 7'b0100000 && funct3 == 3'b000) op = cpu_pkg::OP_SUB;
        else if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000: op = cpu_pkg::OP_ADD;
            3'b100: op = cpu_pkg::OP_XOR;
            3'b110: op = cpu_pkg::OP_OR;
            3'b111: op = cpu_pkg::OP_AND;
            default: ;
          endcase
        end
      end
      cpu_pkg::OPC_IMM: if (funct3 == 3'b000) op = cpu_pkg::OP_ADDI;
      cpu_pkg::OPC_LOAD: if (funct3 == 3'b010) op = cpu_pkg::OP_LW;
      cpu_pkg::OPC_STORE: if (funct3 == 3'b010) op = cpu_pkg::OP_SW;
      default: ;
    endcase
  end

  assign imm = (op == cpu_pkg::OP_SW) ?
               {{20{fetch_in.instr[31]}}, fetch_in.instr[31:25], fetch_in.instr[11:7]} :
               {{20{fetch_in.instr[31]}}, fetch_in.instr[31:20]};
  assign writes = (op != cpu_pkg::OP_NOP) && (op != cpu_pkg::OP_SW) && (rd != '0);
  assign use_rs2 = !(op inside {cpu_pkg::OP_NOP, cpu_pkg::OP_ADDI, cpu_pkg::OP_LW});

  // Interlock against every writer still in flight.
  assign own_writes = issue_valid && issue_out.writes;
  assign rs1_busy = hits(rs1_addr, ex_rd, ex_writes) || hits(rs1_addr, mem_rd, mem_writes) ||
                    hits(rs1_addr, issue_out.rd, own_writes);
  assign rs2_busy = hits(rs2_addr, ex_rd, ex_writes) || hits(rs2_addr, mem_rd, mem_writes) ||
                    hits(rs2_addr, issue_out.rd, own_writes);
  assign hazard = fetch_valid && (((op != cpu_pkg::OP_NOP) && rs1_busy) || (use_rs2 && rs2_busy));

  assign fetch_ready = !hazard && (!issue_valid || issue_ready);
  assign take = fetch_valid && fetch_ready;

  always_ff @(posedge clock) begin
    if (!rst_n) issue_valid <= 1'b0;
    else if (take) issue_valid <= 1'b1;
    else if (issue_ready) issue_valid <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (take) begin
      issue_out <= '{op: op, rd: rd, rs1_val: rs1_data, rs2_val: rs2_data,
                     imm: imm, writes: writes};
    end
  end

  a_issue_hold: assert property (@(posedge clock) disable iff (!rst_n)
    issue_valid && !issue_ready |=> issue_valid && $stable(issue_out))
    else $error("issued instruction changed before execute was ready");

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  logic                  clock,
  input  logic                  rst_n,
  input  cpu_pkg::issue_t       issue_in,
  input  logic                  issue_valid,
  output logic                  issue_ready,
  output cpu_pkg::execute_out_t exec_out,
  output logic                  exec_valid,
  input  logic                  exec_ready,
  output cpu_pkg::reg_addr_t    ex_rd,
  output logic                  ex_writes
);

  cpu_pkg::word_t result;
  logic take;

  always_comb begin
    case (issue_in.op)
      cpu_pkg::OP_ADD: result = issue_in.rs1_val + issue_in.rs2_val;
      cpu_pkg::OP_SUB: result = issue_in.rs1_val - issue_in.rs2_val;
      cpu_pkg::OP_AND: result = issue_in.rs1_val & issue_in.rs2_val;
      cpu_pkg::OP_OR: result = issue_in.rs1_val | issue_in.rs2_val;
      cpu_pkg::OP_XOR: result = issue_in.rs1_val ^ issue_in.rs2_val;
      // Address generation shares the immediate adder.
      cpu_pkg::OP_ADDI, cpu_pkg::OP_LW, cpu_pkg::OP_SW: result = issue_in.rs1_val + issue_in.imm;
      default: result = '0;
    endcase
  end

  assign issue_ready = !exec_valid || exec_ready;
  assign take = issue_valid && issue_ready;

  always_ff @(posedge clock) begin
    if (!rst_n) exec_valid <= 1'b0;
    else if (take) exec_valid <= 1'b1;
    else if (exec_ready) exec_valid <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (take) begin
      exec_out <= '{op: issue_in.op, rd: issue_in.rd, result: result,
                    store_data: issue_in.rs2_val, writes: issue_in.writes};
    end
  end

  assign ex_rd = exec_out.rd;
  assign ex_writes = exec_valid && exec_out.writes; // Seen by the decode interlock.

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
  parameter int FETCH_DEPTH = 4
) (
  input  logic                clock,
  input  logic                rst_n,
  output cpu_pkg::mem_req_t   imem_req,
  input  cpu_pkg::mem_rsp_t   imem_rsp,
  output cpu_pkg::fetch_out_t fetch_out,
  output logic                fetch_valid,
  input  logic                fetch_ready
);

  localparam int PTR_W = $clog2(FETCH_DEPTH);
  localparam int CNT_W = $clog2(FETCH_DEPTH + 1);

  cpu_pkg::fetch_out_t queue [FETCH_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  cpu_pkg::addr_t pc;
  logic started; // Holds off the first request one cycle past reset.
  logic push;
  logic pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FETCH_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Room only grows while a request waits, so valid holds until ready.
  assign imem_req.valid = started && (count < CNT_W'(FETCH_DEPTH));
  assign imem_req.instr = 1'b1;
  assign imem_req.store = 1'b0;
  assign imem_req.addr = pc;
  assign imem_req.wdata = '0;

  assign push = imem_req.valid && imem_rsp.ready;
  assign fetch_valid = count != '0;
  assign pop = fetch_valid && fetch_ready;
  assign fetch_out = queue[rd_ptr];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      started <= 1'b0;
      pc <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      started <= 1'b1;
      if (push) begin
        pc <= pc + 32'd4;
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (push) queue[wr_ptr] <= '{instr: imem_rsp.rdata, pc: pc};
  end

  a_imem_hold: assert property (@(posedge clock) disable iff (!rst_n)
    imem_req.valid && !imem_rsp.ready |=> imem_req.valid && $stable(imem_req))
    else $error("instruction request changed before ready");

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
  input  logic                  clock,
  input  logic                  rst_n,
  input  cpu_pkg::execute_out_t exec_in,
  input  logic                  exec_valid,
  output logic                  exec_ready,
  output cpu_pkg::mem_req_t     dmem_req,
  input  cpu_pkg::mem_rsp_t     dmem_rsp,
  output cpu_pkg::reg_write_t   reg_wr,
  output cpu_pkg::reg_addr_t    mem_rd,
  output logic                  mem_writes
);

  typedef enum logic [1:0] {MEM_IDLE, MEM_WAIT, MEM_WRITE} mem_state_t;

  mem_state_t state;
  cpu_pkg::execute_out_t held;
  logic take;
  logic is_mem_op;
  logic load_done;

  assign exec_ready = state != MEM_WAIT; // Blocked while the data port is busy.
  assign take = exec_valid && exec_ready;
  assign is_mem_op = exec_in.op inside {cpu_pkg::OP_LW, cpu_pkg::OP_SW};

  assign dmem_req.valid = state == MEM_WAIT;
  assign dmem_req.instr = 1'b0;
  assign dmem_req.store = held.op == cpu_pkg::OP_SW;
  assign dmem_req.addr = held.result;
  assign dmem_req.wdata = held.store_data;

  assign load_done = dmem_req.valid && dmem_rsp.ready && (held.op == cpu_pkg::OP_LW);

  assign reg_wr.en = held.writes && ((state == MEM_WRITE) || load_done);
  assign reg_wr.rd = held.rd;
  assign reg_wr.data = (state == MEM_WAIT) ? dmem_rsp.rdata : held.result;

  assign mem_rd = held.rd;
  assign mem_writes = (state != MEM_IDLE) && held.writes;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= MEM_IDLE;
    end else if (take) begin
      if (is_mem_op) state <= MEM_WAIT;
      else state <= MEM_WRITE;
    end else if (state == MEM_WRITE || (state == MEM_WAIT && dmem_rsp.ready)) begin
      state <= MEM_IDLE;
    end
  end

  always_ff @(posedge clock) begin
    if (take) held <= exec_in;
  end

  a_dmem_hold: assert property (@(posedge clock) disable iff (!rst_n)
    dmem_req.valid && !dmem_rsp.ready |=> dmem_req.valid && $stable(dmem_req))
    else $error("data request changed before ready");

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic               clock,
  input  logic               rst_n,
  input  cpu_pkg::reg_addr_t rs1_addr,
  input  cpu_pkg::reg_addr_t rs2_addr,
  output cpu_pkg::word_t     rs1_data,
  output cpu_pkg::word_t     rs2_data,
  input  cpu_pkg::reg_write_t wr
);

  cpu_pkg::word_t regs [1:15]; // x0 has no storage.

  // Same-cycle write is visible to the reader.
  assign rs1_data = (rs1_addr == '0) ? '0 :
                    (wr.en && wr.rd == rs1_addr) ? wr.data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 :
                    (wr.en && wr.rd == rs2_addr) ? wr.data : regs[rs2_addr];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 1; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.en && wr.rd != '0) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // Decode never marks x0 as a destination.
  a_no_x0_write: assert property (@(posedge clock) disable iff (!rst_n)
    wr.en |-> wr.rd != '0) else $error("register write to x0");

endmodule
